//--- source/dma_pkg.sv
// dma descriptor engine package: shared widths, request, descriptor and axi4-lite types
`default_nettype none

package dma_pkg;

  // --------------------
  // axi4-lite
  localparam int AXIL_ADDR_W = 8;
  localparam int AXIL_DATA_W = 32;
  localparam logic [1:0] AXIL_RESP_OKAY = 2'b00;

  typedef struct packed {
    logic [AXIL_ADDR_W-1:0]   addr;
  } axil_aw_t;

  typedef struct packed {
    logic [AXIL_DATA_W-1:0]   data;
    logic [AXIL_DATA_W/8-1:0] strb;   // one bit per byte lane
  } axil_w_t;

  typedef struct packed {
    logic [AXIL_DATA_W-1:0]   data;
    logic [1:0]               resp;
  } axil_r_t;

  // --------------------
  // channel request as programmed by software
  typedef struct packed {
    logic [31:0] saddr;
    logic [31:0] daddr;
    logic [15:0] length;   // bytes
    logic [3:0]  tag;
  } chan_req_t;

  // --------------------
  // descriptor words, two views of one 64-bit word
  typedef struct packed {
    logic [23:0] rsvd_hi;      // zero
    logic [3:0]  tag;          // 39:36
    logic        rsvd_35;
    logic        saddr_b2;     // saddr bit 2, host side quirk
    logic [1:0]  rsvd_33;
    logic        valid;        // always one
    logic        dir;          // 0 = tohost
    logic [2:0]  daddr_b3_1;
    logic [10:0] rsvd_lo;      // byte enables unused here
    logic [15:0] dw_count;     // 32-bit words in the transfer
  } desc_hdr_t;

  typedef struct packed {
    logic [31:0] daddr;
    logic [31:0] saddr;        // dword aligned
  } desc_addr_t;

  typedef union packed {
    desc_hdr_t  hdr;
    desc_addr_t addr;
  } desc_word_u;

  typedef struct packed {
    logic [2:0] rsvd;          // undocumented, kept zero
    logic       desc_en;
    logic       is_last;
    logic       demand_mode;
    logic [1:0] half_valid;    // which 32-bit halves hold data
  } desc_ctrl_t;

  typedef struct packed {
    desc_ctrl_t ctrl;
    desc_word_u data;
  } tohost_beat_t;             // 72 bits on the wire

endpackage

`default_nettype wire

//--- source/dma_csr_axil.sv
// dma csr block: axi4-lite slave with per-channel request registers, start pulses and busy
`timescale 1ns/100ps
`default_nettype none

module dma_csr_axil
  import dma_pkg::*;
#(
  parameter int N_CHAN = 4
)
(
  input  logic                   clk,
  input  logic                   rst_n,
  // write address and data
  input  logic                   awvalid,
  output logic                   awready,
  input  axil_aw_t               aw,
  input  logic                   wvalid,
  output logic                   wready,
  input  axil_w_t                w,
  // write response, always okay
  output logic                   bvalid,
  input  logic                   bready,
  // read address and data
  input  logic                   arvalid,
  output logic                   arready,
  input  logic [AXIL_ADDR_W-1:0] araddr,
  output logic                   rvalid,
  input  logic                   rready,
  output axil_r_t                r,
  // arbiter side
  output logic [N_CHAN-1:0]      start,
  output chan_req_t [N_CHAN-1:0] req_regs,
  input  logic [N_CHAN-1:0]      busy
);

  logic                   wr_hs;
  logic                   rd_hs;
  logic [AXIL_ADDR_W-5:0] wr_chan;   // 16 bytes per channel
  logic [AXIL_ADDR_W-5:0] rd_chan;
  logic [1:0]             wr_off;    // dword within channel
  logic [1:0]             rd_off;
  logic [AXIL_DATA_W-1:0] rd_data;

  // byte lane merge of write data into the current value
  function automatic logic [AXIL_DATA_W-1:0] strb_merge(logic [AXIL_DATA_W-1:0] cur,
                                                        axil_w_t wd);
    logic [AXIL_DATA_W-1:0] res;
    res = cur;
    for (int b = 0; b < AXIL_DATA_W/8; b++)
    begin
      if (wd.strb[b])
      begin
        res[8*b +: 8] = wd.data[8*b +: 8];
      end
    end
    return res;
  endfunction

  // length/tag word, only 20 bits are stored
  function automatic logic [19:0] merge_len(chan_req_t cur, axil_w_t wd);
    logic [AXIL_DATA_W-1:0] res;
    res = strb_merge({12'b0, cur.tag, cur.length}, wd);
    return res[19:0];
  endfunction

  // --------------------
  // handshakes
  assign wr_hs   = awvalid && wvalid && !bvalid;   // both channels together
  assign awready = wr_hs;
  assign wready  = wr_hs;
  assign rd_hs   = arvalid && !rvalid;             // one read outstanding
  assign arready = rd_hs;

  assign wr_chan = aw.addr[AXIL_ADDR_W-1:4];
  assign wr_off  = aw.addr[3:2];
  assign rd_chan = araddr[AXIL_ADDR_W-1:4];
  assign rd_off  = araddr[3:2];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      bvalid <= 1'b0;
      rvalid <= 1'b0;
    end
    else
    begin
      if (wr_hs)
        bvalid <= 1'b1;
      else if (bready)
        bvalid <= 1'b0;
      if (rd_hs)
        rvalid <= 1'b1;
      else if (rready)
        rvalid <= 1'b0;
    end
  end

  // --------------------
  // register file
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_regs <= '0;
    end
    else if (wr_hs)
    begin
      for (int c = 0; c < N_CHAN; c++)
      begin
        if (wr_chan == c)
        begin
          case (wr_off)
            2'd0: req_regs[c].saddr <= strb_merge(req_regs[c].saddr, w);
            2'd1: req_regs[c].daddr <= strb_merge(req_regs[c].daddr, w);
            2'd2: {req_regs[c].tag, req_regs[c].length} <= merge_len(req_regs[c], w);
            default: ;   // control goes to start below
          endcase
        end
      end
    end
  end

  // start pulse, dropped while the channel is busy
  always_comb
  begin
    start = '0;
    for (int c = 0; c < N_CHAN; c++)
    begin
      start[c] = wr_hs && (wr_chan == c) && (wr_off == 2'd3) &&
                 w.strb[0] && w.data[0] && !busy[c];
    end
  end

  // --------------------
  // read decode, channels past N_CHAN read as zero
  always_comb
  begin
    rd_data = '0;
    for (int c = 0; c < N_CHAN; c++)
    begin
      if (rd_chan == c)
      begin
        case (rd_off)
          2'd0:    rd_data = req_regs[c].saddr;
          2'd1:    rd_data = req_regs[c].daddr;
          2'd2:    rd_data = {12'b0, req_regs[c].tag, req_regs[c].length};
          default: rd_data = {{(AXIL_DATA_W-1){1'b0}}, busy[c]};
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_hs)
    begin
      r.data <= rd_data;
      r.resp <= AXIL_RESP_OKAY;
    end
  end

endmodule

`default_nettype wire

//--- source/chan_arbiter.sv
// channel arbiter: pending bits per channel and round-robin grant to the request generator
`timescale 1ns/100ps
`default_nettype none

module chan_arbiter
  import dma_pkg::*;
#(
  parameter int N_CHAN = 4
)
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [N_CHAN-1:0]      start,
  input  chan_req_t [N_CHAN-1:0] req_regs,
  output logic [N_CHAN-1:0]      busy,
  output chan_req_t              chan_req,
  output logic                   chan_valid,
  input  logic                   chan_busy
);

  localparam int CH_W = (N_CHAN > 1) ? $clog2(N_CHAN) : 1;

  logic [N_CHAN-1:0] pending_q;
  logic [N_CHAN-1:0] in_svc_q;    // accepted, generator still working
  logic [CH_W-1:0]   first_q;     // where the search begins
  logic [CH_W-1:0]   gnt_idx;
  logic              gnt_found;
  logic              accept;
  logic [N_CHAN-1:0] clr_mask;

  // round-robin search from first_q
  always_comb
  begin
    int idx;
    gnt_idx   = '0;
    gnt_found = 1'b0;
    for (int i = 0; i < N_CHAN; i++)
    begin
      idx = (int'(first_q) + i) % N_CHAN;
      if (!gnt_found && pending_q[idx])
      begin
        gnt_found = 1'b1;
        gnt_idx   = CH_W'(idx);
      end
    end
  end

  assign chan_valid = gnt_found;
  assign chan_req   = req_regs[gnt_idx];
  assign accept     = chan_valid && !chan_busy;
  assign clr_mask   = accept ? (N_CHAN'(1) << gnt_idx) : '0;
  assign busy       = pending_q | in_svc_q;   // seen by the csr block

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pending_q <= '0;
      in_svc_q  <= '0;
      first_q   <= '0;
    end
    else
    begin
      pending_q <= (pending_q | start) & ~clr_mask;
      if (accept)
      begin
        in_svc_q <= clr_mask;
        first_q  <= (gnt_idx == CH_W'(N_CHAN-1)) ? '0 : gnt_idx + 1'b1;   // wrap
      end
      else if (!chan_busy)
      begin
        in_svc_q <= '0;   // generator back in idle
      end
    end
  end

endmodule

`default_nettype wire

//--- source/downstream_req.sv
// downstream request generator: builds header and address descriptor words for the tohost FIFO
`timescale 1ns/100ps
`default_nettype none

module downstream_req
  import dma_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  // request from arbiter
  input  chan_req_t    chan_req,
  input  logic         chan_valid,
  output logic         chan_busy,
  // tohost FIFO
  input  logic         almost_full,
  output logic         push,
  output tohost_beat_t push_beat
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_INIT,   // wait for FIFO room
    S_DESC    // address word
  } state_t;

  localparam desc_ctrl_t HDR_CTRL = '{
    rsvd:        3'b000,
    desc_en:     1'b1,
    is_last:     1'b0,
    demand_mode: 1'b1,
    half_valid:  2'b11
  };
  localparam desc_ctrl_t ADDR_CTRL = '{
    rsvd:        3'b000,
    desc_en:     1'b1,
    is_last:     1'b1,
    demand_mode: 1'b1,
    half_valid:  2'b11
  };

  state_t      state;
  chan_req_t   req_q;
  logic        accept;
  logic [15:0] nbytes;       // length plus start misalignment
  logic [15:0] nbytes_rnd;
  logic [15:0] dw_count;
  desc_word_u  hdr_word;
  desc_word_u  addr_word;

  assign chan_busy = (state != S_IDLE);
  assign accept    = chan_valid && !chan_busy;

  // --------------------
  // dword count, ceil((len + saddr%4)/4), 16-bit wrap
  assign nbytes     = req_q.length + {14'b0, req_q.saddr[1:0]};
  assign nbytes_rnd = nbytes + 16'd3;
  assign dw_count   = {2'b00, nbytes_rnd[15:2]};

  always_comb
  begin
    hdr_word                = '0;
    hdr_word.hdr.tag        = req_q.tag;
    hdr_word.hdr.saddr_b2   = req_q.saddr[2];
    hdr_word.hdr.valid      = 1'b1;
    hdr_word.hdr.dir        = 1'b0;           // tohost
    hdr_word.hdr.daddr_b3_1 = req_q.daddr[3:1];
    hdr_word.hdr.dw_count   = dw_count;
  end

  always_comb
  begin
    addr_word.addr.daddr = req_q.daddr;
    addr_word.addr.saddr = {req_q.saddr[31:2], 2'b00};   // dword aligned
  end

  // --------------------
  // FSM
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= S_IDLE;
      push  <= 1'b0;
    end
    else
    begin
      case (state)
        S_IDLE:
        begin
          push <= 1'b0;
          if (accept)
            state <= S_INIT;
        end
        S_INIT:
        begin
          push <= !almost_full;        // header once two slots are free
          if (!almost_full)
            state <= S_DESC;
        end
        S_DESC:
        begin
          push  <= 1'b1;               // address word right behind
          state <= S_IDLE;
        end
        default:
        begin
          push  <= 1'b0;
          state <= S_IDLE;
        end
      endcase
    end
  end

  // request latch and beat payload
  always_ff @(posedge clk)
  begin
    if (accept)
      req_q <= chan_req;
    if (state == S_INIT && !almost_full)
    begin
      push_beat.ctrl <= HDR_CTRL;
      push_beat.data <= hdr_word;
    end
    else if (state == S_DESC)
    begin
      push_beat.ctrl <= ADDR_CTRL;   // is_last set
      push_beat.data <= addr_word;
    end
  end

endmodule

`default_nettype wire

//--- source/tohost_fifo.sv
// tohost FIFO: first-word-fall-through buffer with almost-full flag and valid/ready output
`timescale 1ns/100ps
`default_nettype none

module tohost_fifo
  import dma_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
)
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         push,
  input  tohost_beat_t push_beat,
  output logic         almost_full,
  output tohost_beat_t tohost_beat,
  output logic         tohost_valid,
  input  logic         tohost_ready
);

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam logic [AW:0] DEPTH_CNT = (AW+1)'(FIFO_DEPTH);

  tohost_beat_t  mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;      // wraps naturally, depth is 2^n
  logic [AW-1:0] rd_ptr;
  logic [AW:0]   count;
  logic          full;
  logic          wr_en;
  logic          rd_en;

  assign full         = (count == DEPTH_CNT);
  assign wr_en        = push && !full;
  assign rd_en        = tohost_valid && tohost_ready;
  assign tohost_valid = (count != '0);
  assign tohost_beat  = mem[rd_ptr];                     // fall through
  assign almost_full  = (count >= DEPTH_CNT - 1'b1);     // under two free

  always_ff @(posedge clk)
  begin
    if (wr_en)
      mem[wr_ptr] <= push_beat;
  end

  // --------------------
  // pointers and occupancy
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_en)
        rd_ptr <= rd_ptr + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;   // both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

//--- source/dma_desc_top.sv
// dma descriptor engine top: csr block, arbiter, request generator and tohost FIFO
`timescale 1ns/100ps
`default_nettype none

module dma_desc_top
  import dma_pkg::*;
#(
  parameter int N_CHAN     = 4,
  parameter int FIFO_DEPTH = 8
)
(
  input  logic                   clk,
  input  logic                   rst_n,
  // axi4-lite slave
  input  logic                   awvalid,
  output logic                   awready,
  input  axil_aw_t               aw,
  input  logic                   wvalid,
  output logic                   wready,
  input  axil_w_t                w,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic                   arvalid,
  output logic                   arready,
  input  logic [AXIL_ADDR_W-1:0] araddr,
  output logic                   rvalid,
  input  logic                   rready,
  output axil_r_t                r,
  // tohost stream
  output tohost_beat_t           tohost_beat,
  output logic                   tohost_valid,
  input  logic                   tohost_ready
);

  logic [N_CHAN-1:0]      start;
  chan_req_t [N_CHAN-1:0] req_regs;
  logic [N_CHAN-1:0]      busy;
  chan_req_t              chan_req;
  logic                   chan_valid;
  logic                   chan_busy;
  logic                   push;
  tohost_beat_t           push_beat;
  logic                   almost_full;

  // --------------------
  // input side
  dma_csr_axil #(
    .N_CHAN (N_CHAN)
  ) i_dma_csr_axil (
    .clk      (clk),
    .rst_n    (rst_n),
    .awvalid  (awvalid),
    .awready  (awready),
    .aw       (aw),
    .wvalid   (wvalid),
    .wready   (wready),
    .w        (w),
    .bvalid   (bvalid),
    .bready   (bready),
    .arvalid  (arvalid),
    .arready  (arready),
    .araddr   (araddr),
    .rvalid   (rvalid),
    .rready   (rready),
    .r        (r),
    .start    (start),
    .req_regs (req_regs),
    .busy     (busy)
  );

  // --------------------
  // processing
  chan_arbiter #(
    .N_CHAN (N_CHAN)
  ) i_chan_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .req_regs   (req_regs),
    .busy       (busy),
    .chan_req   (chan_req),
    .chan_valid (chan_valid),
    .chan_busy  (chan_busy)
  );

  downstream_req i_downstream_req (
    .clk         (clk),
    .rst_n       (rst_n),
    .chan_req    (chan_req),
    .chan_valid  (chan_valid),
    .chan_busy   (chan_busy),
    .almost_full (almost_full),
    .push        (push),
    .push_beat   (push_beat)
  );

  // --------------------
  // output side
  tohost_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_tohost_fifo (
    .clk          (clk),
    .rst_n        (rst_n),
    .push         (push),
    .push_beat    (push_beat),
    .almost_full  (almost_full),
    .tohost_beat  (tohost_beat),
    .tohost_valid (tohost_valid),
    .tohost_ready (tohost_ready)
  );

endmodule

`default_nettype wire

//--- dv/tb_dma_desc.sv
// dma descriptor engine testbench: axi4-lite programming, descriptor checks and back-pressure
`timescale 1ns/100ps
`default_nettype none

module tb_dma_desc
  import dma_pkg::*;
();

  localparam int N_ROWS      = 8;
  localparam int TIMEOUT_CYC = 300 * N_ROWS + 2000;

  typedef struct packed {
    logic [1:0]  chan;
    logic [31:0] saddr;
    logic [31:0] daddr;
    logic [15:0] length;
    logic [3:0]  tag;
  } row_t;

  typedef enum logic [1:0] {RDY_HIGH, RDY_LOW, RDY_RANDOM} rdy_mode_t;

  logic         clk = 1'b0;
  logic         rst_n;
  logic         awvalid;
  logic         awready;
  logic         wvalid;
  logic         wready;
  logic         bvalid;
  logic         bready;
  logic         arvalid;
  logic         arready;
  logic         rvalid;
  logic         rready;
  axil_aw_t     aw;
  axil_w_t      w;
  axil_r_t      r;
  logic [7:0]   araddr;
  tohost_beat_t tohost_beat;
  logic         tohost_valid;
  logic         tohost_ready;
  rdy_mode_t    ready_mode = RDY_HIGH;
  row_t         rows [N_ROWS];
  tohost_beat_t beat_q [$];     // beats seen at the host side
  int           cycles = 0;

  dma_desc_top #(
    .N_CHAN     (4),
    .FIFO_DEPTH (4)
  ) i_dma_desc_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .awvalid      (awvalid),
    .awready      (awready),
    .aw           (aw),
    .wvalid       (wvalid),
    .wready       (wready),
    .w            (w),
    .bvalid       (bvalid),
    .bready       (bready),
    .arvalid      (arvalid),
    .arready      (arready),
    .araddr       (araddr),
    .rvalid       (rvalid),
    .rready       (rready),
    .r            (r),
    .tohost_beat  (tohost_beat),
    .tohost_valid (tohost_valid),
    .tohost_ready (tohost_ready)
  );

  always #4 clk = ~clk;   // 8 ns period

  // --------------------
  // helpers
  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [71:0] got, input logic [71:0] exp);
    if (got !== exp)
    begin
      $display("ERR %s got %h expected %h", name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // header word built from the descriptor format rules
  function automatic logic [63:0] expect_header(input row_t rw);
    logic [15:0] nbytes;
    logic [63:0] h;
    nbytes    = rw.length + 16'(rw.saddr[1:0]);   // 16-bit wrap
    h         = '0;
    h[39:36]  = rw.tag;
    h[34]     = rw.saddr[2];
    h[31]     = 1'b1;          // valid
    h[30]     = 1'b0;          // tohost
    h[29:27]  = rw.daddr[3:1];
    h[15:0]   = (nbytes / 16'd4) + ((nbytes % 16'd4 != 16'd0) ? 16'd1 : 16'd0);   // round up
    return h;
  endfunction

  function automatic logic [63:0] expect_address(input row_t rw);
    return {rw.daddr, rw.saddr[31:2], 2'b00};
  endfunction

  // rsvd, desc_en, is_last, demand_mode, half_valid
  function automatic logic [7:0] expect_ctrl(input logic last);
    return {3'b000, 1'b1, last, 1'b1, 2'b11};
  endfunction

  task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    awvalid = 1'b1;
    wvalid  = 1'b1;
    aw.addr = addr;
    w.data  = data;
    w.strb  = 4'hf;
    @(posedge clk);
    while (!awready)
      @(posedge clk);
    check_value("wready", wready, 1'b1);   // both channels together
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    @(posedge clk);
    while (!bvalid)
      @(posedge clk);   // bready held high
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
    @(negedge clk);
    arvalid = 1'b1;
    araddr  = addr;
    @(posedge clk);
    while (!arready)
      @(posedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    @(posedge clk);
    while (!rvalid)
      @(posedge clk);
    data = r.data;
    check_value("rresp", r.resp, 2'b00);
  endtask

  task automatic next_beat(output tohost_beat_t b);
    while (beat_q.size() == 0)
      @(negedge clk);
    b = beat_q.pop_front();
  endtask

  task automatic check_pair(input row_t rw, input tohost_beat_t hb, input tohost_beat_t ab);
    check_value("hdr ctrl", hb.ctrl, expect_ctrl(1'b0));
    check_value("hdr word", hb.data, expect_header(rw));
    check_value("addr ctrl", ab.ctrl, expect_ctrl(1'b1));
    check_value("addr word", ab.data, expect_address(rw));
  endtask

  // --------------------
  // one channel alone with ready high
  task automatic run_single(input row_t rw);
    logic [7:0]   base;
    logic [31:0]  rd;
    tohost_beat_t hb;
    tohost_beat_t ab;
    base = {2'b00, rw.chan, 4'h0};
    axil_write(base, rw.saddr);
    axil_write(base + 8'h4, rw.daddr);
    axil_write(base + 8'h8, {12'h000, rw.tag, rw.length});
    axil_read(base, rd);
    check_value("saddr reg", rd, rw.saddr);
    axil_read(base + 8'h4, rd);
    check_value("daddr reg", rd, rw.daddr);
    axil_read(base + 8'h8, rd);
    check_value("len/tag reg", rd, {12'h000, rw.tag, rw.length});
    axil_write(base + 8'hc, 32'h1);   // start
    axil_read(base + 8'hc, rd);
    check_value("busy after start", rd, 32'h1);
    next_beat(hb);
    next_beat(ab);    // must be the very next beat
    check_pair(rw, hb, ab);
    repeat (8) @(negedge clk);
    axil_read(base + 8'hc, rd);
    check_value("busy when done", rd, 32'h0);
    if (beat_q.size() != 0)
      stop_run("extra beat after a single descriptor");
  endtask

  // all channels against a full FIFO and a random drain
  task automatic run_multi();
    row_t         pend [$];
    tohost_beat_t hb;
    tohost_beat_t ab;
    logic [31:0]  rd;
    int           hit;
    ready_mode = RDY_LOW;
    for (int c = 0; c < 4; c++)
      axil_write(8'(16 * c + 12), 32'h1);
    axil_write(8'h2c, 32'h1);   // repeat starts while busy
    axil_write(8'h3c, 32'h1);
    axil_read(8'h3c, rd);
    check_value("busy ch3 under back-pressure", rd, 32'h1);
    for (int i = N_ROWS - 4; i < N_ROWS; i++)
      pend.push_back(rows[i]);  // last values written per channel
    ready_mode = RDY_RANDOM;
    for (int n = 0; n < 4; n++)
    begin
      next_beat(hb);
      next_beat(ab);
      hit = -1;
      for (int k = 0; k < pend.size(); k++)
        if (pend[k].tag == hb.data.hdr.tag)
          hit = k;
      if (hit < 0)
        stop_run("header beat with an unknown or repeated tag");
      check_pair(pend[hit], hb, ab);
      pend.delete(hit);
    end
    repeat (30) @(negedge clk);
    if (beat_q.size() != 0)
      stop_run("unmatched beat after all descriptors");
    for (int c = 0; c < 4; c++)
    begin
      axil_read(8'(16 * c + 12), rd);
      check_value("busy after drain", rd, 32'h0);
    end
  endtask

  // --------------------
  // host side monitor, ready driver and timeout
  always @(posedge clk)
  begin
    if (rst_n && tohost_valid && tohost_ready)
      beat_q.push_back(tohost_beat);
  end

  initial
  begin
    void'($urandom(18));
    tohost_ready = 1'b1;
    forever
    begin
      @(negedge clk);
      case (ready_mode)
        RDY_HIGH: tohost_ready = 1'b1;
        RDY_LOW:  tohost_ready = 1'b0;
        default:  tohost_ready = 1'($urandom % 2);
      endcase
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYC)
      stop_run("timeout: the DUT did not finish in the cycle budget");
  end

  initial
  begin
    logic [31:0] rd;
    rst_n   = 1'b0;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    aw      = '0;
    w       = '0;
    bready  = 1'b1;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b1;
    // chan, saddr, daddr, length, tag
    rows[0] = '{2'd0, 32'h1000_0000, 32'h8000_0040, 16'd64,    4'h1};
    rows[1] = '{2'd1, 32'h1000_1001, 32'h8000_1006, 16'd13,    4'h2};
    rows[2] = '{2'd2, 32'h2000_0006, 32'h9000_000a, 16'd100,   4'h3};
    rows[3] = '{2'd3, 32'h3000_0007, 32'ha000_000e, 16'd7,     4'h4};
    rows[4] = '{2'd0, 32'h4000_0104, 32'hb000_0002, 16'd1,     4'h5};
    rows[5] = '{2'd1, 32'h5000_0203, 32'hc000_0008, 16'd4096,  4'h6};
    rows[6] = '{2'd2, 32'h6000_0002, 32'hd000_0004, 16'hfffe,  4'h7};   // count wraps
    rows[7] = '{2'd3, 32'h7000_0005, 32'he000_000c, 16'd31,    4'h8};
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < N_ROWS; i++)
      run_single(rows[i]);
    axil_read(8'h40, rd);
    check_value("unmapped 0x40", rd, 32'h0);
    axil_read(8'hcc, rd);
    check_value("unmapped 0xcc", rd, 32'h0);
    run_multi();
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
source/dma_pkg.sv
source/dma_csr_axil.sv
source/chan_arbiter.sv
source/downstream_req.sv
source/tohost_fifo.sv
source/dma_desc_top.sv
dv/tb_dma_desc.sv

//--- run_sim.sh
#!/bin/sh
# build and run the dma descriptor engine testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal \
  --top-module tb_dma_desc \
  -f compile.f \
  -o tb_dma_desc
# $fatal in the testbench gives a failing exit status
./obj_dir/tb_dma_desc
